// ==== logic/ffu_pkg.sv ====
/* shared widths, FSR/GSR field positions and select encodings for the FP front-end
   datapath, imported by every RTL block */
package ffu_pkg;

   ////////////////////////////////////////
   // datapath widths
   ////////////////////////////////////////
   localparam int DATA_W  = 64;   // fp register / operand / store data
   localparam int WORD_W  = 32;   // single-precision word
   localparam int NUM_THR = 4;
   localparam int THR_W   = 2;

   ////////////////////////////////////////
   // FSR, compact form
   ////////////////////////////////////////
   // field widths
   localparam int FSR_W     = 28;
   localparam int FCC_W     = 8;    // fcc3..fcc0, 2 bits each
   localparam int FCC_HI_W  = 6;    // fcc3..fcc1
   localparam int FCC0_W    = 2;
   localparam int RND_W     = 2;
   localparam int TEM_W     = 5;
   localparam int FTT_W     = 3;
   localparam int EXC_W     = 5;    // aexc and cexc each
   localparam int FSR_LOW_W = 12;   // fcc0, aexc, cexc

   // lsb positions in the compact register, msb first
   localparam int FSR_FCC_HI = 22;
   localparam int FSR_RND    = 20;
   localparam int FSR_TEM    = 15;
   localparam int FSR_FTT    = 12;
   localparam int FSR_FCC0   = 10;
   localparam int FSR_AEXC   = 5;
   localparam int FSR_CEXC   = 0;

   // lsb positions in the architectural 64-bit FSR image
   localparam int ST_FCC_HI = 32;   // 37:32
   localparam int ST_RND    = 30;   // 31:30
   localparam int ST_TEM    = 23;   // 27:23
   localparam int ST_FTT    = 14;   // 16:14

   ////////////////////////////////////////
   // GSR
   ////////////////////////////////////////
   localparam int GSR_W       = 37;
   localparam int GSR_SCALE_W = 5;    // low bits
   localparam int GSR_MASK_W  = 32;   // upper bits

   // selects from the control block
   typedef enum logic [1:0] {NOSHIFT, SHIFT_RIGHT, SHIFT_LEFT} frf_shift_e;
   typedef enum logic [1:0] {LSU_DIRECT, LSU_FLIP, FPU_DIRECT, FPU_FLIP} in_sel_e;
   typedef enum logic [1:0] {RS2_KEEP, RS2_FRF, RS2_RETURN} rs2_src_e;
   typedef enum logic [1:0] {FSR_KEEP, FSR_LOAD, FSR_FPU} fsr_op_e;
   typedef enum logic [1:0] {ST_RS2, ST_RS1, ST_FRF, ST_FSR} st_sel_e;

endpackage

// ==== logic/frf_align.sv ====
/* places register-file read data for singles: word shift plus optional
   clearing of the low word, feeds rs1/rs2 and the store mux */
`timescale 1ns/1ps

module frf_align import ffu_pkg::*; (
   input  logic [DATA_W-1:0] frf_data,
   input  frf_shift_e        frf_shift,
   input  logic              zero_low32,
   output logic [DATA_W-1:0] aligned
);

   logic [DATA_W-1:0] shifted;

   // a double passes through untouched; a single is moved to the half
   // its consumer expects (lsu wants low, fpu wants high)
   always_comb begin
      case (frf_shift)
         SHIFT_RIGHT: begin
            shifted = {{WORD_W{1'b0}}, frf_data[DATA_W-1:WORD_W]};  // upper to lower
         end
         SHIFT_LEFT: begin
            shifted = {frf_data[WORD_W-1:0], {WORD_W{1'b0}}};       // lower to upper
         end
         default: begin
            shifted = frf_data;
         end
      endcase
   end

   // clear the low word
   always_comb begin
      aligned = shifted;
      if (zero_low32) begin
         aligned[WORD_W-1:0] = '0;
      end
   end

endmodule

// ==== logic/operand_regs.sv ====
/* operand registers: flopped LSU/FPU return data with flip mux, rs1 and rs2
   with sign override, and the register-file write data one cycle behind rs2 */
`timescale 1ns/1ps

module operand_regs import ffu_pkg::*; (
   input  logic              rclk,
   input  logic [DATA_W-1:0] ld_data,
   input  logic [DATA_W-1:0] fpu_data,
   input  logic [DATA_W-1:0] aligned,
   input  in_sel_e           in_sel,
   input  logic              rs1_load,
   input  rs2_src_e          rs2_src,
   input  logic [1:0]        sign,
   output logic [DATA_W-1:0] ld_data_d1,
   output logic [DATA_W-1:0] rs1,
   output logic [DATA_W-1:0] rs2,
   output logic [DATA_W-1:0] frf_wdata,
   output logic [1:0]        rs2_sign,
   output logic [FCC_W-1:0]  ld_fcc
);

   logic [DATA_W-1:0] fpu_data_d1;
   logic [DATA_W-1:0] ret_data;     // selected return data
   logic [DATA_W-1:0] frf_signed;   // aligned data with FABS/FNEG sign

   ////////////////////////////////////////
   // return data
   ////////////////////////////////////////
   always_ff @(posedge rclk) begin
      ld_data_d1  <= ld_data;
      fpu_data_d1 <= fpu_data;
   end

   // fcc fields straight from the flopped load, for ldxfsr
   assign ld_fcc = {ld_data_d1[ST_FCC_HI +: FCC_HI_W], ld_data_d1[FSR_FCC0 +: FCC0_W]};

   always_comb begin
      case (in_sel)
         LSU_FLIP:   ret_data = {ld_data_d1[WORD_W-1:0], {WORD_W{1'b0}}};
         FPU_DIRECT: ret_data = fpu_data_d1;
         FPU_FLIP:   ret_data = {{WORD_W{1'b0}}, fpu_data_d1[DATA_W-1:WORD_W]};
         default:    ret_data = ld_data_d1;
      endcase
   end

   ////////////////////////////////////////
   // rs1 / rs2
   ////////////////////////////////////////
   assign rs2_sign   = {aligned[DATA_W-1], aligned[WORD_W-1]};
   assign frf_signed = {sign[1], aligned[DATA_W-2:WORD_W],
                        sign[0], aligned[WORD_W-2:0]};

   always_ff @(posedge rclk) begin
      if (rs1_load) begin
         rs1 <= aligned;
      end
      case (rs2_src)
         RS2_FRF:    rs2 <= frf_signed;
         RS2_RETURN: rs2 <= ret_data;
         default:    rs2 <= rs2;       // hold
      endcase
      frf_wdata <= rs2;   // block loads are pipelined, write lags by one
   end

endmodule

// ==== logic/fsr_bank.sv ====
/* per-thread FSR storage; updated by ldfsr or an FPU result for fsr_thr,
   read out and decoded for fp_thr */
`timescale 1ns/1ps

module fsr_bank import ffu_pkg::*; (
   input  logic                 rclk,
   input  logic                 rst_n,
   input  logic [DATA_W-1:0]    ld_data_d1,
   input  fsr_op_e              fsr_op,
   input  logic [THR_W-1:0]     fsr_thr,
   input  logic [THR_W-1:0]     fp_thr,
   input  logic [FCC_W-1:0]     fcc_w2,
   input  logic [2*EXC_W-1:0]   exc_w2,
   input  logic [FTT_W-1:0]     ftt_w2,
   output logic [FSR_W-1:0]     current_fsr,
   output logic [FCC_W-1:0]     fsr_fcc,
   output logic [RND_W-1:0]     fsr_rnd,
   output logic [TEM_W-1:0]     fsr_tem,
   output logic [EXC_W-1:0]     fsr_aexc,
   output logic [EXC_W-1:0]     fsr_cexc
);

   logic [FSR_W-1:0] fsr_q [NUM_THR];
   logic [FSR_W-1:0] old_fsr;    // thread being updated
   logic [FSR_W-1:0] ld_fsr;
   logic [FSR_W-1:0] fpu_fsr;

   assign old_fsr = fsr_q[fsr_thr];

   ////////////////////////////////////////
   // next value
   ////////////////////////////////////////
   // ldfsr: reserved, ver, ns and qne bits are not kept
   assign ld_fsr = {fcc_w2[FCC_W-1:FCC0_W],                // fcc3..1
                    ld_data_d1[ST_RND +: RND_W],
                    ld_data_d1[ST_TEM +: TEM_W],
                    old_fsr[FSR_FTT +: FTT_W],             // ftt survives a load
                    ld_data_d1[FSR_LOW_W-1:0]};            // fcc0, aexc, cexc

   // fpu result keeps the mode bits
   assign fpu_fsr = {fcc_w2[FCC_W-1:FCC0_W],
                     old_fsr[FSR_RND +: RND_W],
                     old_fsr[FSR_TEM +: TEM_W],
                     ftt_w2,
                     fcc_w2[FCC0_W-1:0],
                     exc_w2};

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         for (int t = 0; t < NUM_THR; t++) begin
            fsr_q[t] <= '0;
         end
      end else begin
         case (fsr_op)
            FSR_LOAD: fsr_q[fsr_thr] <= ld_fsr;
            FSR_FPU:  fsr_q[fsr_thr] <= fpu_fsr;
            default:  ;
         endcase
      end
   end

   ////////////////////////////////////////
   // current thread decode
   ////////////////////////////////////////
   assign current_fsr = fsr_q[fp_thr];

   assign fsr_fcc  = {current_fsr[FSR_FCC_HI +: FCC_HI_W], current_fsr[FSR_FCC0 +: FCC0_W]};
   assign fsr_rnd  = current_fsr[FSR_RND +: RND_W];
   assign fsr_tem  = current_fsr[FSR_TEM +: TEM_W];
   assign fsr_aexc = current_fsr[FSR_AEXC +: EXC_W];
   assign fsr_cexc = current_fsr[FSR_CEXC +: EXC_W];

endmodule

// ==== logic/gsr_bank.sv ====
/* per-thread GSR storage (mask and scale only), written from wsr data and
   read for the executing thread */
`timescale 1ns/1ps

module gsr_bank import ffu_pkg::*; (
   input  logic                   rclk,
   input  logic                   rst_n,
   input  logic                   gsr_wr,
   input  logic [THR_W-1:0]       gsr_wr_thr,
   input  logic [THR_W-1:0]       gsr_rd_thr,
   input  logic [GSR_W-1:0]       wsr_data,
   output logic [GSR_MASK_W-1:0]  gsr_mask,
   output logic [GSR_SCALE_W-1:0] gsr_scale
);

   logic [GSR_W-1:0] gsr_q [NUM_THR];
   logic [GSR_W-1:0] gsr_rd;

   always_ff @(posedge rclk) begin
      if (!rst_n) begin
         for (int t = 0; t < NUM_THR; t++) begin
            gsr_q[t] <= '0;
         end
      end else if (gsr_wr) begin
         gsr_q[gsr_wr_thr] <= wsr_data;
      end
   end

   // align and rnd fields live in the control block
   assign gsr_rd    = gsr_q[gsr_rd_thr];
   assign gsr_mask  = gsr_rd[GSR_W-1 -: GSR_MASK_W];   // upper bits
   assign gsr_scale = gsr_rd[GSR_SCALE_W-1:0];

endmodule

// ==== logic/ffu_dp.sv ====
/* FP front-end datapath top: operand alignment and registers, FSR and GSR
   banks, and the store data mux toward the LSU */
`timescale 1ns/1ps

module ffu_dp import ffu_pkg::*; (
   input  logic                   rclk,
   input  logic                   rst_n,
   input  logic [DATA_W-1:0]      frf_data,
   input  logic [DATA_W-1:0]      ld_data,
   input  logic [DATA_W-1:0]      fpu_data,
   input  frf_shift_e             frf_shift,
   input  logic                   zero_low32,
   input  logic [1:0]             sign,        // after FABS/FNEG
   input  in_sel_e                in_sel,
   input  logic                   rs1_load,
   input  rs2_src_e               rs2_src,
   input  st_sel_e                st_sel,
   input  fsr_op_e                fsr_op,
   input  logic [THR_W-1:0]       fsr_thr,
   input  logic [THR_W-1:0]       fp_thr,
   input  logic [FCC_W-1:0]       fcc_w2,
   input  logic [2*EXC_W-1:0]     exc_w2,
   input  logic [FTT_W-1:0]       ftt_w2,
   input  logic                   gsr_wr,
   input  logic [THR_W-1:0]       gsr_wr_thr,
   input  logic [THR_W-1:0]       gsr_rd_thr,
   input  logic [GSR_W-1:0]       wsr_data,
   output logic [DATA_W-1:0]      frf_wdata,
   output logic [DATA_W-1:0]      lsu_data,
   output logic [1:0]             rs2_sign,
   output logic [FCC_W-1:0]       ld_fcc,
   output logic [FCC_W-1:0]       fsr_fcc,
   output logic [RND_W-1:0]       fsr_rnd,
   output logic [TEM_W-1:0]       fsr_tem,
   output logic [EXC_W-1:0]       fsr_aexc,
   output logic [EXC_W-1:0]       fsr_cexc,
   output logic [GSR_MASK_W-1:0]  gsr_mask,
   output logic [GSR_SCALE_W-1:0] gsr_scale
);

   logic [DATA_W-1:0] aligned;
   logic [DATA_W-1:0] ld_data_d1;
   logic [DATA_W-1:0] rs1;
   logic [DATA_W-1:0] rs2;
   logic [FSR_W-1:0]  current_fsr;
   logic [DATA_W-1:0] fsr_store;    // architectural FSR image

   frf_align u_frf_align (
      .frf_data   (frf_data),
      .frf_shift  (frf_shift),
      .zero_low32 (zero_low32),
      .aligned    (aligned)
   );

   operand_regs u_operand_regs (
      .rclk       (rclk),
      .ld_data    (ld_data),
      .fpu_data   (fpu_data),
      .aligned    (aligned),
      .in_sel     (in_sel),
      .rs1_load   (rs1_load),
      .rs2_src    (rs2_src),
      .sign       (sign),
      .ld_data_d1 (ld_data_d1),
      .rs1        (rs1),
      .rs2        (rs2),
      .frf_wdata  (frf_wdata),
      .rs2_sign   (rs2_sign),
      .ld_fcc     (ld_fcc)
   );

   fsr_bank u_fsr_bank (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .ld_data_d1  (ld_data_d1),
      .fsr_op      (fsr_op),
      .fsr_thr     (fsr_thr),
      .fp_thr      (fp_thr),
      .fcc_w2      (fcc_w2),
      .exc_w2      (exc_w2),
      .ftt_w2      (ftt_w2),
      .current_fsr (current_fsr),
      .fsr_fcc     (fsr_fcc),
      .fsr_rnd     (fsr_rnd),
      .fsr_tem     (fsr_tem),
      .fsr_aexc    (fsr_aexc),
      .fsr_cexc    (fsr_cexc)
   );

   gsr_bank u_gsr_bank (
      .rclk       (rclk),
      .rst_n      (rst_n),
      .gsr_wr     (gsr_wr),
      .gsr_wr_thr (gsr_wr_thr),
      .gsr_rd_thr (gsr_rd_thr),
      .wsr_data   (wsr_data),
      .gsr_mask   (gsr_mask),
      .gsr_scale  (gsr_scale)
   );

   ////////////////////////////////////////
   // store data to LSU
   ////////////////////////////////////////
   // stfsr: spread compact fields back out, reserved bits read zero
   always_comb begin
      fsr_store = '0;
      fsr_store[ST_FCC_HI +: FCC_HI_W] = current_fsr[FSR_FCC_HI +: FCC_HI_W];
      fsr_store[ST_RND +: RND_W]       = current_fsr[FSR_RND +: RND_W];
      fsr_store[ST_TEM +: TEM_W]       = current_fsr[FSR_TEM +: TEM_W];
      fsr_store[ST_FTT +: FTT_W]       = current_fsr[FSR_FTT +: FTT_W];
      fsr_store[FSR_LOW_W-1:0]         = current_fsr[FSR_LOW_W-1:0];   // fcc0, aexc, cexc
   end

   always_comb begin
      case (st_sel)
         ST_RS1:  lsu_data = rs1;
         ST_FRF:  lsu_data = aligned;     // direct store from the frf
         ST_FSR:  lsu_data = fsr_store;
         default: lsu_data = rs2;
      endcase
   end

endmodule

// ==== tb/ffu_dp_tests.svh ====
/* directed tests for the FP front-end datapath, included inside the testbench
   module; expected values follow the FSR, GSR and operand rules */

// FSR store image after ldfsr keeps the old ftt
function automatic logic [63:0] load_image(logic [63:0] old, logic [63:0] ld, logic [7:0] fcc);
   logic [63:0] img;
   img = '0;
   img[37:32] = fcc[7:2];
   img[31:30] = ld[31:30];
   img[27:23] = ld[27:23];
   img[16:14] = old[16:14];
   img[11:0]  = ld[11:0];
   return img;
endfunction

function automatic logic [63:0] fpu_image(logic [63:0] old, logic [7:0] fcc,
                                          logic [9:0] exc, logic [2:0] ftt);
   logic [63:0] img;
   img = old & 64'h0000_0000_CF80_0000;   // rnd and tem kept
   img[37:32] = fcc[7:2];
   img[16:14] = ftt;
   img[11:0]  = {fcc[1:0], exc};
   return img;
endfunction

function automatic logic [63:0] align_ref(logic [63:0] d, frf_shift_e shift, logic z);
   logic [63:0] a;
   case (shift)
      SHIFT_RIGHT: a = {32'h0, d[63:32]};
      SHIFT_LEFT:  a = {d[31:0], 32'h0};
      default:     a = d;
   endcase
   if (z) begin
      a[31:0] = 32'h0;
   end
   return a;
endfunction

task automatic read_fsr(input logic [1:0] thr);
   logic [63:0] img;
   next_cycle();
   fsr_op = FSR_KEEP;
   fp_thr = thr;
   st_sel = ST_FSR;
   settle();
   img = fsr_img[thr];
   check_value("fsr_fcc", 64'(fsr_fcc), 64'({img[37:32], img[11:10]}));
   check_value("fsr_rnd", 64'(fsr_rnd), 64'(img[31:30]));
   check_value("fsr_tem", 64'(fsr_tem), 64'(img[27:23]));
   check_value("fsr_aexc", 64'(fsr_aexc), 64'(img[9:5]));
   check_value("fsr_cexc", 64'(fsr_cexc), 64'(img[4:0]));
   check_value("lsu_data", lsu_data, img);   // ftt only visible here
endtask

task automatic read_gsr(input logic [1:0] thr);
   logic [63:0] r;
   next_cycle();
   r = rand_bits(GSR_W);
   gsr_wr = 1'b0;
   wsr_data = r[GSR_W-1:0];   // must not land
   gsr_rd_thr = thr;
   settle();
   check_value("gsr_mask", 64'(gsr_mask), 64'(gsr_exp[thr][36:5]));
   check_value("gsr_scale", 64'(gsr_scale), 64'(gsr_exp[thr][4:0]));
endtask

task automatic reset_test();
   for (int t = 0; t < NUM_THR; t++) begin
      read_fsr(t[1:0]);
      read_gsr(t[1:0]);
   end
endtask

// load data one cycle ahead of the FSR_LOAD op
task automatic load_fsr(input logic [1:0] thr);
   logic [63:0] ld;
   logic [63:0] r;
   next_cycle();
   ld = rand_bits(64);
   ld_data = ld;
   fsr_op = FSR_KEEP;
   next_cycle();
   r = rand_bits(8);
   fsr_op = FSR_LOAD;
   fsr_thr = thr;
   fcc_w2 = r[7:0];
   settle();
   check_value("ld_fcc", 64'(ld_fcc), 64'({ld[37:32], ld[11:10]}));
   fsr_img[thr] = load_image(fsr_img[thr], ld, r[7:0]);
endtask

task automatic fsr_test();
   logic [63:0] r;
   for (int t = 0; t < NUM_THR; t++) begin
      load_fsr(t[1:0]);
      for (int u = 0; u < NUM_THR; u++) begin
         read_fsr(u[1:0]);   // only thread t moved
      end
      next_cycle();
      r = rand_bits(21);
      fsr_op = FSR_FPU;
      fcc_w2 = r[7:0];
      exc_w2 = r[17:8];
      ftt_w2 = r[20:18];
      fsr_img[t[1:0]] = fpu_image(fsr_img[t[1:0]], r[7:0], r[17:8], r[20:18]);
      read_fsr(t[1:0]);
      load_fsr(t[1:0]);   // ftt from the fpu update survives
      read_fsr(t[1:0]);
   end
endtask

task automatic gsr_test();
   logic [63:0] r;
   for (int t = 0; t < NUM_THR; t++) begin
      next_cycle();
      r = rand_bits(GSR_W);
      gsr_wr = 1'b1;
      gsr_wr_thr = t[1:0];
      wsr_data = r[GSR_W-1:0];
      gsr_exp[t[1:0]] = r[GSR_W-1:0];
      read_gsr(t[1:0]);
   end
   for (int t = 0; t < NUM_THR; t++) begin
      read_gsr(t[1:0]);
   end
endtask

task automatic align_case(input frf_shift_e shift, input logic z);
   logic [63:0] r;
   logic [63:0] al;
   logic [63:0] rs2_exp;
   logic [63:0] rs2_next;
   next_cycle();
   r = rand_bits(64);
   al = align_ref(r, shift, z);
   frf_data = r;
   frf_shift = shift;
   zero_low32 = z;
   r = rand_bits(2);
   sign = r[1:0];
   rs1_load = 1'b1;
   rs2_src = RS2_FRF;
   st_sel = ST_FRF;
   settle();
   check_value("lsu_data", lsu_data, al);
   check_value("rs2_sign", 64'(rs2_sign), 64'({al[63], al[31]}));
   rs2_exp = {r[1], al[62:32], r[0], al[30:0]};
   // rs1 holds while rs2 takes the new frf data
   next_cycle();
   r = rand_bits(64);
   frf_data = r;
   rs1_load = 1'b0;
   st_sel = ST_RS1;
   settle();
   check_value("lsu_data", lsu_data, al);
   al = align_ref(r, shift, z);
   rs2_next = {sign[1], al[62:32], sign[0], al[30:0]};
   next_cycle();
   rs2_src = RS2_KEEP;
   st_sel = ST_RS2;
   settle();
   check_value("lsu_data", lsu_data, rs2_next);
   check_value("frf_wdata", frf_wdata, rs2_exp);   // one edge behind rs2
   next_cycle();
   settle();
   check_value("lsu_data", lsu_data, rs2_next);    // held
   check_value("frf_wdata", frf_wdata, rs2_next);
endtask

task automatic return_case(input in_sel_e sel);
   logic [63:0] ld;
   logic [63:0] fp;
   logic [63:0] exp_rs2;
   next_cycle();
   ld = rand_bits(64);
   fp = rand_bits(64);
   ld_data = ld;
   fpu_data = fp;
   rs2_src = RS2_KEEP;
   next_cycle();
   in_sel = sel;
   rs2_src = RS2_RETURN;
   ld_data = ~ld;    // too late for this rs2 load
   fpu_data = ~fp;
   next_cycle();
   rs2_src = RS2_KEEP;
   st_sel = ST_RS2;
   settle();
   case (sel)
      LSU_FLIP:   exp_rs2 = {ld[31:0], 32'h0};
      FPU_DIRECT: exp_rs2 = fp;
      FPU_FLIP:   exp_rs2 = {32'h0, fp[63:32]};
      default:    exp_rs2 = ld;
   endcase
   check_value("lsu_data", lsu_data, exp_rs2);
endtask

// ==== tb/ffu_dp_tb.sv ====
/* testbench for the FP front-end datapath: clock, reset, stimulus helpers and
   the test order; the directed tests live in the included test file */
`timescale 1ns/1ps

module ffu_dp_tb import ffu_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 200;   // about twice the ~100 cycle sequence

   logic rclk, rst_n;
   logic [DATA_W-1:0] frf_data, ld_data, fpu_data;
   frf_shift_e frf_shift;
   logic zero_low32;
   logic [1:0] sign;
   in_sel_e in_sel;
   logic rs1_load;
   rs2_src_e rs2_src;
   st_sel_e st_sel;
   fsr_op_e fsr_op;
   logic [THR_W-1:0] fsr_thr, fp_thr, gsr_wr_thr, gsr_rd_thr;
   logic [FCC_W-1:0] fcc_w2;
   logic [2*EXC_W-1:0] exc_w2;
   logic [FTT_W-1:0] ftt_w2;
   logic gsr_wr;
   logic [GSR_W-1:0] wsr_data;
   logic [DATA_W-1:0] frf_wdata, lsu_data;
   logic [1:0] rs2_sign;
   logic [FCC_W-1:0] ld_fcc, fsr_fcc;
   logic [RND_W-1:0] fsr_rnd;
   logic [TEM_W-1:0] fsr_tem;
   logic [EXC_W-1:0] fsr_aexc, fsr_cexc;
   logic [GSR_MASK_W-1:0] gsr_mask;
   logic [GSR_SCALE_W-1:0] gsr_scale;

   logic [63:0] fsr_img [NUM_THR];      // expected FSR store image per thread
   logic [GSR_W-1:0] gsr_exp [NUM_THR];
   logic [15:0] lfsr_q = 16'd18;
   int cycle_cnt = 0;

   ffu_dp u_ffu_dp (.*);

   ////////////////////////////////////////
   // clock and run limit
   ////////////////////////////////////////
   initial begin
      rclk = 1'b0;
      forever #2 rclk = ~rclk;
   end

   always @(posedge rclk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $fatal(1);
      end
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   // x^16 + x^14 + x^13 + x^11 + 1, shifting right
   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
   endfunction

   function automatic logic [63:0] rand_bits(int n);
      logic [63:0] out;
      out = '0;
      for (int i = 0; i < n; i++) begin
         out    = {out[62:0], lfsr_q[0]};   // one step per bit
         lfsr_q = lfsr_next(lfsr_q);
      end
      return out;
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("ERROR %s: actual %h expected %h", name, actual, expected);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic next_cycle();
      @(posedge rclk);
      #1;   // drive point
   endtask

   task automatic settle();
      #1;   // outputs stable before the next edge
   endtask

   task automatic init_inputs();
      rst_n = 1'b0;
      frf_data = '0;
      ld_data = '0;
      fpu_data = '0;
      frf_shift = NOSHIFT;
      zero_low32 = 1'b0;
      sign = 2'b00;
      in_sel = LSU_DIRECT;
      rs1_load = 1'b0;
      rs2_src = RS2_KEEP;
      st_sel = ST_RS2;
      fsr_op = FSR_KEEP;
      {fsr_thr, fp_thr, gsr_wr_thr, gsr_rd_thr} = '0;
      {fcc_w2, exc_w2, ftt_w2} = '0;
      gsr_wr = 1'b0;
      wsr_data = '0;
      fsr_img = '{default: '0};
      gsr_exp = '{default: '0};
   endtask

   `include "ffu_dp_tests.svh"

   initial begin
      init_inputs();
      repeat (2) @(posedge rclk);
      #1;
      rst_n = 1'b1;
      reset_test();
      fsr_test();
      gsr_test();
      align_case(NOSHIFT, 1'b0);
      align_case(NOSHIFT, 1'b1);
      align_case(SHIFT_RIGHT, 1'b0);
      align_case(SHIFT_RIGHT, 1'b1);
      align_case(SHIFT_LEFT, 1'b0);
      align_case(SHIFT_LEFT, 1'b1);
      return_case(LSU_DIRECT);
      return_case(LSU_FLIP);
      return_case(FPU_DIRECT);
      return_case(FPU_FLIP);
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+tb
logic/ffu_pkg.sv
logic/frf_align.sv
logic/operand_regs.sv
logic/fsr_bank.sv
logic/gsr_bank.sv
logic/ffu_dp.sv
tb/ffu_dp_tb.sv

// ==== Makefile ====
# Verilator build and run of the FP front-end datapath testbench

TOP := ffu_dp_tb

all: run

run:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
